// ==== files.f ====
common/mem_pkg.sv
common/cache_pkg.sv
design/main_mem_ctrl.sv
icache/icache_ctrl.sv
dcache/dcache_ctrl.sv
design/mem_subsys_top.sv
tb/iomem_model.sv
tb/tb_mem_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f files.f --top-module tb_mem_subsys -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "Testbench passed" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== tb/tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int          TIMEOUT = 400;     // cycles per handshake phase
    localparam logic [31:0] SEED    = 32'h31bf;

    logic clk;
    logic rst;
    logic fetch_req;
    addr_t fetch_addr;
    logic fetch_ack;
    word_t fetch_data;
    logic data_req;
    logic data_we;
    addr_t data_addr;
    word_t data_wdata;
    logic data_ack;
    word_t data_rdata;
    logic iomem_valid;
    addr_t iomem_addr;
    word_t iomem_wdata;
    strb_t iomem_wstrb;
    logic iomem_ready;
    word_t iomem_rdata;
    logic stall_en;
    logic [3:0] stall_mask;

    word_t stored [addr_t];         // words written through the data port
    addr_t bus_blocks [$];          // first address of each bus transfer
    string test_name = "reset";
    int checks = 0;
    int errors = 0;
    int tests_done = 0;
    int base_checks;
    int base_errors;
    logic [31:0] rng = SEED;
    logic fetch_ack_q = 1'b0;
    logic data_ack_q = 1'b0;
    logic valid_q = 1'b0;
    logic run_ended = 1'b0;

    mem_subsys_top #(
        .ICACHE_LINES (4),
        .DCACHE_LINES (4)
    ) u_mem_subsys_top (
        .clk_i (clk), .rst_i (rst),
        .fetch_req_i (fetch_req), .fetch_addr_i (fetch_addr),
        .fetch_ack_o (fetch_ack), .fetch_data_o (fetch_data),
        .data_req_i (data_req), .data_we_i (data_we), .data_addr_i (data_addr),
        .data_wdata_i (data_wdata), .data_ack_o (data_ack), .data_rdata_o (data_rdata),
        .iomem_valid_o (iomem_valid), .iomem_addr_o (iomem_addr),
        .iomem_wdata_o (iomem_wdata), .iomem_wstrb_o (iomem_wstrb),
        .iomem_ready_i (iomem_ready), .iomem_rdata_i (iomem_rdata)
    );

    iomem_model u_iomem (
        .clk_i (clk), .stall_en_i (stall_en), .stall_mask_i (stall_mask),
        .valid_i (iomem_valid), .addr_i (iomem_addr), .wdata_i (iomem_wdata),
        .wstrb_i (iomem_wstrb), .ready_o (iomem_ready), .rdata_o (iomem_rdata)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t ref_word(input addr_t addr);
        return xorshift(addr ^ SEED);           // power-up content of memory
    endfunction

    function automatic word_t expected_word(input addr_t addr);
        if (stored.exists(addr)) return stored[addr];
        return ref_word(addr);
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    task automatic finish_run();
        run_ended = 1'b1;
        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what, input addr_t addr);
        if (!run_ended) begin
            errors++;
            $display("%s: %s within %0d cycles at address %08h", test_name, what, TIMEOUT,
                     addr);
            finish_run();
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        base_checks = checks;
        base_errors = errors;
    endtask

    task automatic end_test();
        tests_done++;
        $display("test %0d %s: %0d checks, %0d errors", tests_done, test_name,
                 checks - base_checks, errors - base_errors);
    endtask

    // four-phase fetch entered and left 2 ns after a rising edge
    task automatic fetch_word(input addr_t addr);
        int n;
        fetch_addr = addr;
        fetch_req  = 1'b1;
        n = 0;
        while (fetch_ack !== 1'b1) begin
            @(posedge clk);
            #2;
            n++;
            if (n > TIMEOUT) fail_timeout("fetch ack did not rise", addr);
        end
        fetch_req = 1'b0;
        n = 0;
        while (fetch_ack !== 1'b0) begin
            @(posedge clk);
            #2;
            n++;
            if (n > TIMEOUT) fail_timeout("fetch ack did not fall", addr);
        end
    endtask

    task automatic data_access(input logic we, input addr_t addr, input word_t wdata);
        int n;
        data_we    = we;
        data_addr  = addr;
        data_wdata = wdata;
        data_req   = 1'b1;
        n = 0;
        while (data_ack !== 1'b1) begin
            @(posedge clk);
            #2;
            n++;
            if (n > TIMEOUT) fail_timeout("data ack did not rise", addr);
        end
        data_req = 1'b0;
        n = 0;
        while (data_ack !== 1'b0) begin
            @(posedge clk);
            #2;
            n++;
            if (n > TIMEOUT) fail_timeout("data ack did not fall", addr);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ack and address are stable at the falling edge
    always @(negedge clk) begin
        if (fetch_ack && !fetch_ack_q) begin
            check_value(test_name, expected_word(fetch_addr), fetch_data);
        end
        if (data_ack && !data_ack_q) begin
            if (data_we) stored[data_addr] = data_wdata;
            else check_value(test_name, expected_word(data_addr), data_rdata);
        end
        if (iomem_valid && !valid_q) bus_blocks.push_back(iomem_addr);
        fetch_ack_q = fetch_ack;
        data_ack_q  = data_ack;
        valid_q     = iomem_valid;
    end

    initial begin
        addr_t a;
        addr_t x;
        addr_t f;
        word_t v;
        logic [31:0] r;
        int kind;
        addr_t addrs [$];

        rst = 1'b0;
        fetch_req = 1'b0;
        fetch_addr = '0;
        data_req = 1'b0;
        data_we = 1'b0;
        data_addr = '0;
        data_wdata = '0;
        stall_en = 1'b0;
        stall_mask = 4'h0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b1;

        begin_test("fetch");
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < 16; i++) begin
                a = 32'h100 + 32'(i) * 32'h24;
                fetch_word(a);
                if (pass == 0) fetch_word(a);     // same line again hits
            end
        end
        end_test();

        begin_test("store_load");
        for (int i = 0; i < 16; i++) begin
            r = next_rand();
            a = 32'h1000 + {24'b0, r[7:2], 2'b00};
            addrs.push_back(a);
            data_access(1'b1, a, next_rand());
        end
        foreach (addrs[i]) data_access(1'b0, addrs[i], '0);
        end_test();

        begin_test("dirty_evict");
        a = 32'h2010;
        x = 32'h2050;                             // same index with another tag
        v = next_rand();
        data_access(1'b1, a, v);
        data_access(1'b0, x, '0);
        check_value(test_name, v, u_iomem.mem[a[13:2]]);
        data_access(1'b0, a, '0);
        end_test();

        begin_test("priority");
        data_access(1'b0, 32'h3020, '0);          // leaves index 2 clean
        x = 32'h3060;
        f = 32'h0f40;
        bus_blocks.delete();
        fork
            fetch_word(f);
            data_access(1'b0, x, '0);
        join
        if (bus_blocks.size() != 2) begin
            errors++;
            $display("%s: expected 2 bus transfers but saw %0d", test_name, bus_blocks.size());
        end else begin
            check_value(test_name, {x[31:4], 4'b0}, bus_blocks[0]);
            check_value(test_name, {f[31:4], 4'b0}, bus_blocks[1]);
        end
        end_test();

        begin_test("stalls");
        stall_en   = 1'b1;
        stall_mask = 4'h3;
        for (int i = 0; i < 48; i++) begin
            r = next_rand();
            kind = r % 3;
            case (kind)
                0: fetch_word({23'b0, r[8:2], 2'b00});
                1: data_access(1'b0, 32'h2000 + {23'b0, r[8:2], 2'b00}, '0);
                default: data_access(1'b1, 32'h2000 + {23'b0, r[8:2], 2'b00}, next_rand());
            endcase
        end
        end_test();

        finish_run();
    end

endmodule

`default_nettype wire

// ==== tb/iomem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module iomem_model #(
    parameter int WORDS = 4096
) (
    input  logic        clk_i,
    input  logic        stall_en_i,
    input  logic [3:0]  stall_mask_i,
    input  logic        valid_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  wstrb_i,
    output logic        ready_o,
    output logic [31:0] rdata_o
);
    localparam int IDX_W = $clog2(WORDS);

    logic [31:0] mem [WORDS];
    logic [31:0] rng_q;
    logic [3:0]  stall_q;         // wait cycles left before the next beat

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        rng_q   = 32'h31bf;
        stall_q = 4'd0;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = xorshift(32'(i * 4) ^ 32'h31bf);   // byte address of the word
        end
    end

    assign ready_o = valid_i && (stall_q == 4'd0);
    assign rdata_o = mem[addr_i[IDX_W+1:2]];

    always @(posedge clk_i) begin
        if (valid_i) begin
            if (stall_q != 4'd0) begin
                stall_q <= stall_q - 4'd1;
            end else begin
                for (int b = 0; b < 4; b++) begin   // one strobe bit per byte lane
                    if (wstrb_i[b]) mem[addr_i[IDX_W+1:2]][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
                if (stall_en_i) begin     // stall drawn for the following beat
                    rng_q   <= xorshift(rng_q);
                    stall_q <= rng_q[3:0] & stall_mask_i;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
    parameter int ICACHE_LINES = 16,
    parameter int DCACHE_LINES = 16
) (
    input  logic           clk_i,
    input  logic           rst_i,
    // fetch port
    input  logic           fetch_req_i,
    input  mem_pkg::addr_t fetch_addr_i,
    output logic           fetch_ack_o,
    output mem_pkg::word_t fetch_data_o,
    // data port
    input  logic           data_req_i,
    input  logic           data_we_i,
    input  mem_pkg::addr_t data_addr_i,
    input  mem_pkg::word_t data_wdata_i,
    output logic           data_ack_o,
    output mem_pkg::word_t data_rdata_o,
    // memory bus
    output logic           iomem_valid_o,
    output mem_pkg::addr_t iomem_addr_o,
    output mem_pkg::word_t iomem_wdata_o,
    output mem_pkg::strb_t iomem_wstrb_o,
    input  logic           iomem_ready_i,
    input  mem_pkg::word_t iomem_rdata_i
);
    import mem_pkg::*;

    logic   ic_req;
    addr_t  ic_addr;
    logic   ic_ready;
    logic   dc_req;
    addr_t  dc_addr;
    logic   dc_we;
    block_t dc_wblock;
    logic   dc_ready;
    block_t rblock;      // shared by both caches

    icache_ctrl #(
        .LINES (ICACHE_LINES)
    ) u_icache (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fetch_req_i  (fetch_req_i),
        .fetch_addr_i (fetch_addr_i),
        .fetch_ack_o  (fetch_ack_o),
        .fetch_data_o (fetch_data_o),
        .mem_req_o    (ic_req),
        .mem_addr_o   (ic_addr),
        .mem_ready_i  (ic_ready),
        .mem_rblock_i (rblock)
    );

    dcache_ctrl #(
        .LINES (DCACHE_LINES)
    ) u_dcache (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .data_req_i   (data_req_i),
        .data_we_i    (data_we_i),
        .data_addr_i  (data_addr_i),
        .data_wdata_i (data_wdata_i),
        .data_ack_o   (data_ack_o),
        .data_rdata_o (data_rdata_o),
        .mem_req_o    (dc_req),
        .mem_addr_o   (dc_addr),
        .mem_we_o     (dc_we),
        .mem_wblock_o (dc_wblock),
        .mem_ready_i  (dc_ready),
        .mem_rblock_i (rblock)
    );

    main_mem_ctrl u_main_mem_ctrl (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .ic_req_i      (ic_req),
        .ic_addr_i     (ic_addr),
        .dc_req_i      (dc_req),
        .dc_addr_i     (dc_addr),
        .dc_we_i       (dc_we),
        .dc_wblock_i   (dc_wblock),
        .mem_free_o    (),            // caches sequence on their ready pulses
        .rblock_o      (rblock),
        .ic_ready_o    (ic_ready),
        .dc_ready_o    (dc_ready),
        .iomem_valid_o (iomem_valid_o),
        .iomem_addr_o  (iomem_addr_o),
        .iomem_wdata_o (iomem_wdata_o),
        .iomem_wstrb_o (iomem_wstrb_o),
        .iomem_ready_i (iomem_ready_i),
        .iomem_rdata_i (iomem_rdata_i)
    );

endmodule

`default_nettype wire

// ==== dcache/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl #(
    parameter int LINES = 16
) (
    input  logic            clk_i,
    input  logic            rst_i,
    // data port
    input  logic            data_req_i,
    input  logic            data_we_i,
    input  mem_pkg::addr_t  data_addr_i,
    input  mem_pkg::word_t  data_wdata_i,
    output logic            data_ack_o,
    output mem_pkg::word_t  data_rdata_o,
    // controller link
    output logic            mem_req_o,
    output mem_pkg::addr_t  mem_addr_o,
    output logic            mem_we_o,
    output mem_pkg::block_t mem_wblock_o,
    input  logic            mem_ready_i,
    input  mem_pkg::block_t mem_rblock_i
);
    import mem_pkg::*;
    import cache_pkg::*;

    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = $bits(addr_t) - IDX_W - OFFSET_W;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB,
        S_FILL,
        S_ACK
    } state_t;

    state_t           state_q;
    logic [TAG_W-1:0] tag_q  [LINES];
    block_t           data_q [LINES];
    line_state_t      line_q [LINES];

    logic [IDX_W-1:0]      idx;
    logic [TAG_W-1:0]      tag;
    logic [WORD_SEL_W-1:0] sel;
    logic                  hit;
    block_t                hit_blk;    // resident line with store word merged
    block_t                fill_blk;   // refill block with store word merged

    assign idx = data_addr_i[OFFSET_W +: IDX_W];
    assign tag = data_addr_i[$bits(addr_t)-1 -: TAG_W];
    assign sel = data_addr_i[OFFSET_W-WORD_SEL_W +: WORD_SEL_W];
    assign hit = line_q[idx].valid && (tag_q[idx] == tag);

    // victim stays untouched until the refill lands
    assign mem_wblock_o = data_q[idx];

    always_comb begin
        hit_blk  = data_q[idx];
        hit_blk[sel*WORD_W +: WORD_W] = data_wdata_i;
        fill_blk = mem_rblock_i;
        if (data_we_i) fill_blk[sel*WORD_W +: WORD_W] = data_wdata_i;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q    <= S_IDLE;
            data_ack_o <= 1'b0;
            mem_req_o  <= 1'b0;
            mem_we_o   <= 1'b0;
            for (int i = 0; i < LINES; i++) begin
                line_q[i] <= '0;
            end
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (data_req_i) state_q <= S_LOOKUP;
                end
                S_LOOKUP: begin
                    if (hit) begin
                        data_rdata_o <= data_q[idx][sel*WORD_W +: WORD_W];
                        if (data_we_i) begin
                            data_q[idx]       <= hit_blk;
                            line_q[idx].dirty <= 1'b1;
                        end
                        data_ack_o <= 1'b1;
                        state_q    <= S_ACK;
                    end else if (line_q[idx].valid && line_q[idx].dirty) begin
                        // evict to the victim's own address first
                        mem_req_o  <= 1'b1;
                        mem_we_o   <= 1'b1;
                        mem_addr_o <= {tag_q[idx], idx, {OFFSET_W{1'b0}}};
                        state_q    <= S_WB;
                    end else begin
                        mem_req_o  <= 1'b1;
                        mem_we_o   <= 1'b0;
                        mem_addr_o <= {tag, idx, {OFFSET_W{1'b0}}};
                        state_q    <= S_FILL;
                    end
                end
                S_WB: begin
                    if (mem_ready_i) begin
                        mem_req_o <= 1'b0;      // drop, refill raised next cycle
                        state_q   <= S_FILL;
                    end
                end
                S_FILL: begin
                    if (mem_ready_i) begin
                        mem_req_o    <= 1'b0;
                        data_q[idx]  <= fill_blk;
                        tag_q[idx]   <= tag;
                        line_q[idx]  <= '{valid: 1'b1, dirty: data_we_i};
                        data_rdata_o <= mem_rblock_i[sel*WORD_W +: WORD_W];
                        data_ack_o   <= 1'b1;
                        state_q      <= S_ACK;
                    end else if (!mem_req_o) begin
                        mem_req_o  <= 1'b1;     // refill after write-back
                        mem_we_o   <= 1'b0;
                        mem_addr_o <= {tag, idx, {OFFSET_W{1'b0}}};
                    end
                end
                S_ACK: begin
                    if (!data_req_i) begin
                        data_ack_o <= 1'b0;
                        state_q    <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // write-backs only ever carry a valid, dirty victim
    a_wb_dirty: assert property (@(posedge clk_i) disable iff (!rst_i)
        (mem_req_o && mem_we_o) |-> (line_q[idx].valid && line_q[idx].dirty));

endmodule

`default_nettype wire

// ==== icache/icache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
    parameter int LINES = 16
) (
    input  logic            clk_i,
    input  logic            rst_i,
    // fetch port
    input  logic            fetch_req_i,
    input  mem_pkg::addr_t  fetch_addr_i,
    output logic            fetch_ack_o,
    output mem_pkg::word_t  fetch_data_o,
    // controller link
    output logic            mem_req_o,
    output mem_pkg::addr_t  mem_addr_o,
    input  logic            mem_ready_i,
    input  mem_pkg::block_t mem_rblock_i
);
    import mem_pkg::*;
    import cache_pkg::*;

    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = $bits(addr_t) - IDX_W - OFFSET_W;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_FILL,
        S_ACK
    } state_t;

    state_t      state_q;
    logic [TAG_W-1:0] tag_q  [LINES];
    block_t           data_q [LINES];
    line_state_t      line_q [LINES];

    logic [IDX_W-1:0]      idx;
    logic [TAG_W-1:0]      tag;
    logic [WORD_SEL_W-1:0] sel;
    logic                  hit;

    // address held stable by the fetch stage until ack
    assign idx = fetch_addr_i[OFFSET_W +: IDX_W];
    assign tag = fetch_addr_i[$bits(addr_t)-1 -: TAG_W];
    assign sel = fetch_addr_i[OFFSET_W-WORD_SEL_W +: WORD_SEL_W];
    assign hit = line_q[idx].valid && (tag_q[idx] == tag);

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q     <= S_IDLE;
            fetch_ack_o <= 1'b0;
            mem_req_o   <= 1'b0;
            for (int i = 0; i < LINES; i++) begin
                line_q[i] <= '0;
            end
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (fetch_req_i) state_q <= S_LOOKUP;
                end
                S_LOOKUP: begin
                    if (hit) begin
                        fetch_data_o <= data_q[idx][sel*WORD_W +: WORD_W];
                        fetch_ack_o  <= 1'b1;
                        state_q      <= S_ACK;
                    end else begin
                        mem_req_o  <= 1'b1;
                        mem_addr_o <= {tag, idx, {OFFSET_W{1'b0}}};   // block aligned
                        state_q    <= S_FILL;
                    end
                end
                S_FILL: begin
                    if (mem_ready_i) begin
                        mem_req_o    <= 1'b0;
                        data_q[idx]  <= mem_rblock_i;
                        tag_q[idx]   <= tag;
                        line_q[idx]  <= '{valid: 1'b1, dirty: 1'b0};
                        fetch_data_o <= mem_rblock_i[sel*WORD_W +: WORD_W];
                        fetch_ack_o  <= 1'b1;
                        state_q      <= S_ACK;
                    end
                end
                S_ACK: begin
                    if (!fetch_req_i) begin     // four-phase close
                        fetch_ack_o <= 1'b0;
                        state_q     <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // refill request is a level held until the controller answers
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        (mem_req_o && !mem_ready_i) |=> mem_req_o);

endmodule

`default_nettype wire

// ==== design/main_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_mem_ctrl (
    input  logic            clk_i,
    input  logic            rst_i,
    // icache side
    input  logic            ic_req_i,
    input  mem_pkg::addr_t  ic_addr_i,
    // dcache side
    input  logic            dc_req_i,
    input  mem_pkg::addr_t  dc_addr_i,
    input  logic            dc_we_i,
    input  mem_pkg::block_t dc_wblock_i,
    // shared return path
    output logic            mem_free_o,
    output mem_pkg::block_t rblock_o,
    output logic            ic_ready_o,
    output logic            dc_ready_o,
    // memory bus
    output logic            iomem_valid_o,
    output mem_pkg::addr_t  iomem_addr_o,
    output mem_pkg::word_t  iomem_wdata_o,
    output mem_pkg::strb_t  iomem_wstrb_o,
    input  logic            iomem_ready_i,
    input  mem_pkg::word_t  iomem_rdata_i
);
    import mem_pkg::*;

    localparam int                BEAT_W    = $clog2(BLOCK_WORDS);
    localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(BLOCK_WORDS - 1);

    typedef enum logic [1:0] {
        S_FREE,
        S_WRITE,
        S_READ
    } state_t;

    state_t            state_q;
    logic [BEAT_W-1:0] beat_q;
    logic [BEAT_W-1:0] beat_nx;
    logic              owner_dc_q;     // 1 -> dcache owns the transfer
    logic              pulse_busy;

    assign beat_nx = beat_q + 1'b1;

    // requesters still hold req during their ready pulse, so skip that cycle
    assign pulse_busy = ic_ready_o | dc_ready_o;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q       <= S_FREE;
            beat_q        <= '0;
            owner_dc_q    <= 1'b0;
            iomem_valid_o <= 1'b0;
            iomem_wstrb_o <= '0;
            mem_free_o    <= 1'b1;
            ic_ready_o    <= 1'b0;
            dc_ready_o    <= 1'b0;
        end else begin
            ic_ready_o <= 1'b0;               // single-cycle pulses
            dc_ready_o <= 1'b0;
            case (state_q)
                S_FREE: begin
                    beat_q <= '0;
                    if (!pulse_busy && dc_req_i) begin   // memory stage wins
                        owner_dc_q    <= 1'b1;
                        iomem_addr_o  <= dc_addr_i;
                        iomem_valid_o <= 1'b1;
                        mem_free_o    <= 1'b0;
                        if (dc_we_i) begin
                            iomem_wdata_o <= dc_wblock_i[WORD_W-1:0];
                            iomem_wstrb_o <= '1;
                            state_q       <= S_WRITE;
                        end else begin
                            iomem_wstrb_o <= '0;
                            state_q       <= S_READ;
                        end
                    end else if (!pulse_busy && ic_req_i) begin
                        owner_dc_q    <= 1'b0;
                        iomem_addr_o  <= ic_addr_i;
                        iomem_valid_o <= 1'b1;
                        iomem_wstrb_o <= '0;
                        mem_free_o    <= 1'b0;
                        state_q       <= S_READ;
                    end
                end
                S_WRITE: begin
                    if (iomem_ready_i) begin
                        if (beat_q == LAST_BEAT) begin
                            iomem_valid_o <= 1'b0;
                            iomem_wstrb_o <= '0;
                            mem_free_o    <= 1'b1;
                            dc_ready_o    <= 1'b1;   // only the dcache writes
                            state_q       <= S_FREE;
                        end else begin
                            beat_q        <= beat_nx;
                            iomem_addr_o  <= iomem_addr_o + 32'd4;
                            iomem_wdata_o <= dc_wblock_i[beat_nx*WORD_W +: WORD_W];
                        end
                    end
                end
                S_READ: begin
                    if (iomem_ready_i) begin
                        // shift in from the top, word 0 lands in the low bits
                        rblock_o <= {iomem_rdata_i, rblock_o[$bits(block_t)-1:WORD_W]};
                        if (beat_q == LAST_BEAT) begin
                            iomem_valid_o <= 1'b0;
                            mem_free_o    <= 1'b1;
                            dc_ready_o    <= owner_dc_q;
                            ic_ready_o    <= !owner_dc_q;
                            state_q       <= S_FREE;
                        end else begin
                            beat_q       <= beat_nx;
                            iomem_addr_o <= iomem_addr_o + 32'd4;
                        end
                    end
                end
                default: state_q <= S_FREE;
            endcase
        end
    end

    // a read burst never carries a write strobe
    a_read_no_strb: assert property (@(posedge clk_i) disable iff (!rst_i)
        (iomem_valid_o && state_q == S_READ) |-> iomem_wstrb_o == '0);

    // exactly one owner per transfer
    a_one_ready: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(ic_ready_o && dc_ready_o));

endmodule

`default_nettype wire

// ==== common/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // 16-byte lines, four words each
    localparam int OFFSET_W   = 4;    // byte offset inside a line
    localparam int WORD_SEL_W = 2;    // word index inside a line

    // per-line status bits
    typedef struct packed {
        logic valid;
        logic dirty;                  // unused by the icache
    } line_state_t;

endpackage

`default_nettype wire

// ==== common/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    // memory bus geometry
    localparam int WORD_W      = 32;
    localparam int BLOCK_WORDS = 4;   // beats per block transfer

    typedef logic [31:0] addr_t;      // byte address
    typedef logic [WORD_W-1:0] word_t;

    // word 0 in the low bits, word 3 in the top bits
    typedef logic [BLOCK_WORDS*WORD_W-1:0] block_t;

    typedef logic [WORD_W/8-1:0] strb_t;   // zero on reads, all ones on writes

endpackage

`default_nettype wire
